// ==== axi_lite_i2c.f ====
src/i2c_ctrl_pkg.sv
src/axi_lite_slave.sv
src/i2c_reg_file.sv
src/i2c_byte_engine.sv
src/axi_lite_i2c.sv
dv/i2c_target_model.sv
dv/axi_lite_i2c_assertions.sv
dv/tb_axi_lite_i2c.sv

// ==== dv/axi_lite_i2c_assertions.sv ====
/* AXI response hold, bus release in reset, interrupt gating by ien */
`default_nettype none

module axi_lite_i2c_assertions (
  input wire                          clk,
  input wire                          w_axi_rst,
  input wire                          i_awvalid,
  input wire                          i_awready,
  input wire i2c_ctrl_pkg::reg_addr_t i_awaddr,
  input wire                          i_wvalid,
  input wire                          i_wready,
  input wire i2c_ctrl_pkg::reg_data_t i_wdata,
  input wire                          i_bvalid,
  input wire                          i_bready,
  input wire                          i_rvalid,
  input wire                          i_rready,
  input wire                          i_scl_oe,
  input wire                          i_sda_oe,
  input wire                          i_interrupt
);
  timeunit 1ns;
  timeprecision 100ps;
  import i2c_ctrl_pkg::*;

  logic ien_seen;

  // ien as last written to the control register over AXI
  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      ien_seen <= 1'b0;
    end else if (i_awvalid && i_awready && i_wvalid && i_wready &&
                 i_awaddr[7:2] == REG_CONTROL) begin
      ien_seen <= i_wdata[CTRL_IEN_BIT];
    end
  end

  bvalid_hold: assert property (@(posedge clk) disable iff (w_axi_rst)
    (i_bvalid && !i_bready) |=> i_bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge clk) disable iff (w_axi_rst)
    (i_rvalid && !i_rready) |=> i_rvalid)
    else $error("rvalid dropped before rready");

  bus_released: assert property (@(posedge clk)
    w_axi_rst |=> (!i_scl_oe && !i_sda_oe))
    else $error("output enable active after a reset cycle");

  irq_gated: assert property (@(posedge clk) disable iff (w_axi_rst)
    !ien_seen |-> !i_interrupt)
    else $error("interrupt high while ien is clear");

endmodule

bind axi_lite_i2c axi_lite_i2c_assertions asrt0 (
  .clk(clk), .w_axi_rst(w_axi_rst),
  .i_awvalid(i_awvalid), .i_awready(o_awready), .i_awaddr(i_awaddr),
  .i_wvalid(i_wvalid), .i_wready(o_wready), .i_wdata(i_wdata),
  .i_bvalid(o_bvalid), .i_bready(i_bready),
  .i_rvalid(o_rvalid), .i_rready(i_rready),
  .i_scl_oe(o_scl_oe), .i_sda_oe(o_sda_oe),
  .i_interrupt(o_interrupt)
);

`default_nettype wire

// ==== dv/i2c_target_model.sv ====
/* Behavioral I2C target on the wired-AND bus: captures written bytes,
   acknowledges on request and supplies one read byte per transfer */
`default_nettype none

module i2c_target_model (
  input  wire        clk,
  input  wire        w_axi_rst,
  input  wire        i_scl,
  input  wire        i_sda,
  output logic       o_sda_oe,
  input  wire        i_arm,
  input  wire        i_read_mode,
  input  wire        i_ack_en,
  input  wire  [7:0] i_rd_byte,
  output logic [7:0] o_wr_byte,
  output logic       o_ctrl_ack
);
  timeunit 1ns;
  timeprecision 100ps;

  logic       scl_q, sda_q;
  logic [3:0] cnt;
  logic [7:0] shift, rd_q;
  logic       read_q, ack_q, armed, started;

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      cnt        <= '0;
      shift      <= '0;
      rd_q       <= '0;
      read_q     <= 1'b0;
      ack_q      <= 1'b0;
      armed      <= 1'b0;
      started    <= 1'b0;
      o_sda_oe   <= 1'b0;
      o_wr_byte  <= '0;
      o_ctrl_ack <= 1'b0;
    end else begin
      scl_q <= i_scl;
      sda_q <= i_sda;
      if (i_arm) begin
        armed   <= 1'b1;
        started <= 1'b0;
        read_q  <= i_read_mode;
        ack_q   <= i_ack_en;
        rd_q    <= i_rd_byte;
      end
      // SDA moving while SCL stays high is a start or a stop
      if (scl_q && i_scl && (sda_q != i_sda)) begin
        cnt <= '0;
        if (!i_sda && armed) begin
          started <= 1'b1;
        end
      end else if (!scl_q && i_scl) begin
        if (cnt == 4'd8) begin
          cnt        <= '0;
          armed      <= 1'b0;
          o_wr_byte  <= shift;
          o_ctrl_ack <= !i_sda;
        end else begin
          cnt   <= cnt + 4'd1;
          shift <= {shift[6:0], i_sda};
          if (started) begin
            rd_q <= {rd_q[6:0], 1'b0};
          end
        end
      end
      // Own SDA changes only while SCL is low
      if (!i_scl) begin
        if (!armed) begin
          o_sda_oe <= 1'b0;
        end else if (read_q) begin
          o_sda_oe <= started && (cnt < 4'd8) && !rd_q[7];
        end else begin
          o_sda_oe <= (cnt == 4'd8) && ack_q;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_axi_lite_i2c.sv ====
/* Testbench top: clock, reset, AXI-Lite tasks, register model,
   I2C target hookup, directed and random tests with checks */
`default_nettype none

module tb_axi_lite_i2c;
  timeunit 1ns;
  timeprecision 100ps;
  import i2c_ctrl_pkg::*;

  // 40 transfers of 13 bit times at divider 7, plus register traffic
  localparam int CYCLE_LIMIT = 40 * 13 * 4 * (7 + 1) + 4000;
  localparam reg_data_t EXP_VERSION = 32'h1000_0000;
  localparam reg_data_t EXP_RATE    = 32'd50_000_000;
  localparam reg_data_t EXP_DIV_100 = 32'(50_000_000 / (4 * 100_000) - 1);
  localparam reg_data_t EXP_DIV_400 = 32'(50_000_000 / (4 * 400_000) - 1);

  logic clk, w_axi_rst;
  logic awvalid, wvalid, bready, arvalid, rready;
  reg_addr_t awaddr, araddr;
  reg_data_t wdata;
  wire       awready, wready, bvalid, arready, rvalid;
  axi_resp_t bresp, rresp;
  reg_data_t rdata;
  wire       scl_oe, sda_oe, irq, tgt_sda_oe, scl_line, sda_line;
  logic      tgt_arm, tgt_read, tgt_ack_en;
  i2c_byte_t tgt_rd_byte;
  wire [7:0] tgt_wr_byte;
  wire       tgt_ctrl_ack;
  int        cycles;

  // Register model
  logic      m_core_en, m_ien, m_rxack;
  reg_data_t m_div;
  logic [7:0] m_int_en, m_pend;
  i2c_byte_t m_tx, m_rx;

  // Open-drain bus with pull-ups
  assign scl_line = !scl_oe;
  assign sda_line = !(sda_oe || tgt_sda_oe);

  axi_lite_i2c dut0 (
    .clk(clk), .w_axi_rst(w_axi_rst),
    .i_awvalid(awvalid), .i_awaddr(awaddr), .o_awready(awready),
    .i_wvalid(wvalid), .i_wdata(wdata), .o_wready(wready),
    .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
    .i_arvalid(arvalid), .i_araddr(araddr), .o_arready(arready),
    .o_rvalid(rvalid), .i_rready(rready), .o_rresp(rresp), .o_rdata(rdata),
    .i_sda(sda_line), .o_scl_oe(scl_oe), .o_sda_oe(sda_oe), .o_interrupt(irq)
  );

  i2c_target_model tgt0 (
    .clk(clk), .w_axi_rst(w_axi_rst), .i_scl(scl_line), .i_sda(sda_line),
    .o_sda_oe(tgt_sda_oe), .i_arm(tgt_arm), .i_read_mode(tgt_read),
    .i_ack_en(tgt_ack_en), .i_rd_byte(tgt_rd_byte),
    .o_wr_byte(tgt_wr_byte), .o_ctrl_ack(tgt_ctrl_ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: the run exceeded %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "data compare");
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "response compare");
    end
  endtask

  task automatic check_byte(input string name, input i2c_byte_t exp, input i2c_byte_t act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "byte compare");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      $display("Checks failed");
      $fatal(1, "bit compare");
    end
  endtask

  // Waits n cycles and stays 1 ns past the edge
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Enters and leaves 1 ns after a rising edge
  task automatic axi_write(input reg_idx_t idx, input reg_data_t data, output axi_resp_t resp);
    idle_cycles($urandom_range(3));
    awvalid = 1'b1;
    awaddr  = {idx, 2'b00};
    wvalid  = 1'b1;
    wdata   = data;
    do @(negedge clk); while (!(awready && wready));
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    idle_cycles($urandom_range(3));
    bready = 1'b1;
    do @(negedge clk); while (!bvalid);
    resp = bresp;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input reg_idx_t idx, output reg_data_t data, output axi_resp_t resp);
    idle_cycles($urandom_range(3));
    arvalid = 1'b1;
    araddr  = {idx, 2'b00};
    do @(negedge clk); while (!arready);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    idle_cycles($urandom_range(3));
    rready = 1'b1;
    do @(negedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  function automatic axi_resp_t exp_resp(input reg_idx_t idx);
    return (idx > 6'd9) ? RESP_SLVERR : RESP_OKAY;
  endfunction

  function automatic reg_data_t model_word(input reg_idx_t idx);
    case (idx)
      REG_CONTROL:       return {30'd0, m_ien, m_core_en};
      REG_STATUS:        return {24'd0, m_rxack, 7'd0};
      REG_INTERRUPT:     return {24'd0, m_pend};
      REG_INTERRUPT_EN:  return {24'd0, m_int_en};
      REG_CLOCK_RATE:    return EXP_RATE;
      REG_CLOCK_DIVIDER: return m_div;
      REG_TRANSMIT:      return {24'd0, m_tx};
      REG_RECEIVE:       return {24'd0, m_rx};
      REG_VERSION:       return EXP_VERSION;
      default:           return '0;
    endcase
  endfunction

  task automatic reg_write(input string name, input reg_idx_t idx, input reg_data_t data);
    axi_resp_t resp;
    axi_write(idx, data, resp);
    check_resp(name, exp_resp(idx), resp);
    case (idx)
      REG_CONTROL: begin
        m_core_en = data[0];
        m_ien     = data[1];
        if (data[2]) begin
          m_div = EXP_DIV_400;
        end else if (data[3]) begin
          m_div = EXP_DIV_100;
        end
      end
      REG_INTERRUPT:     m_pend   = m_pend & ~data[7:0];
      REG_INTERRUPT_EN:  m_int_en = data[7:0];
      REG_CLOCK_DIVIDER: m_div    = {16'd0, data[15:0]};
      REG_TRANSMIT:      m_tx     = data[7:0];
      default: begin
      end
    endcase
  endtask

  task automatic expect_read(input string name, input reg_idx_t idx);
    reg_data_t data;
    axi_resp_t resp;
    axi_read(idx, data, resp);
    check_resp(name, exp_resp(idx), resp);
    check_data(name, model_word(idx), data);
  endtask

  task automatic check_irq_line(input string name);
    @(negedge clk);
    check_bit(name, m_ien && |(m_pend & m_int_en), irq);
    @(posedge clk);
    #1;
  endtask

  // For a write, flag is the target's ack; for a read, it is the nack bit
  task automatic run_transfer(input logic rd, input logic start, input logic stop,
                              input logic flag, input i2c_byte_t b);
    reg_data_t st;
    axi_resp_t resp;
    logic      rx_ack;
    if (!rd) begin
      reg_write("transmit", REG_TRANSMIT, {24'd0, b});
    end
    tgt_read    = rd;
    tgt_ack_en  = flag;
    tgt_rd_byte = b;
    tgt_arm     = 1'b1;
    @(posedge clk);
    #1;
    tgt_arm = 1'b0;
    reg_write("command", REG_COMMAND,
              {27'd0, rd && flag, !rd, rd, stop, start});
    do axi_read(REG_STATUS, st, resp); while (st[1]);
    rx_ack = rd ? flag : !flag;
    if (m_ien) begin
      m_pend[0] = 1'b1;
      if (rx_ack && !m_rxack) begin
        m_pend[2] = 1'b1;
      end
    end
    m_rxack = rx_ack;
    if (rd) begin
      m_rx = b;
      check_bit("controller ack", !flag, tgt_ctrl_ack);
      expect_read("receive", REG_RECEIVE);
    end else begin
      check_byte("written byte", b, tgt_wr_byte);
    end
    expect_read("status after transfer", REG_STATUS);
    check_irq_line("interrupt after transfer");
  endtask

  initial begin
    reg_idx_t  idx;
    reg_data_t d;
    logic      rd;
    void'($urandom(32'h7208));
    {awvalid, wvalid, bready, arvalid, rready} = '0;
    awaddr = '0;
    araddr = '0;
    wdata  = '0;
    {tgt_arm, tgt_read, tgt_ack_en} = '0;
    tgt_rd_byte = '0;
    {m_ien, m_rxack} = '0;
    m_core_en = 1'b1;
    m_div     = EXP_DIV_100;
    {m_int_en, m_pend, m_tx, m_rx} = '0;
    w_axi_rst = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    w_axi_rst = 1'b0;

    expect_read("version", REG_VERSION);
    expect_read("clock rate", REG_CLOCK_RATE);
    expect_read("divider after reset", REG_CLOCK_DIVIDER);
    expect_read("control after reset", REG_CONTROL);
    expect_read("interrupt after reset", REG_INTERRUPT);
    check_irq_line("interrupt line after reset");

    repeat (40) begin
      case ($urandom_range(3))
        0:       idx = REG_INTERRUPT_EN;
        1:       idx = REG_CLOCK_DIVIDER;
        2:       idx = REG_TRANSMIT;
        default: idx = reg_idx_t'(10 + $urandom_range(53));
      endcase
      if ($urandom_range(1) == 0) begin
        reg_write("random write", idx, $urandom);
      end else begin
        expect_read("random read", idx);
      end
    end

    reg_write("preset 400k", REG_CONTROL, 32'h5);
    expect_read("divider 400k", REG_CLOCK_DIVIDER);
    reg_write("preset 100k", REG_CONTROL, 32'h9);
    expect_read("divider 100k", REG_CLOCK_DIVIDER);
    reg_write("both presets", REG_CONTROL, 32'hD);
    expect_read("divider both", REG_CLOCK_DIVIDER);
    expect_read("control presets", REG_CONTROL);

    reg_write("divider", REG_CLOCK_DIVIDER, 32'd7);
    repeat (12) begin
      run_transfer(1'b0, 1'($urandom), 1'($urandom), 1'($urandom), i2c_byte_t'($urandom));
    end
    // A read always opens with a start, so the target knows its byte begins
    repeat (12) begin
      run_transfer(1'b1, 1'b1, 1'($urandom), 1'($urandom), i2c_byte_t'($urandom));
    end

    reg_write("control ien", REG_CONTROL, 32'h3);
    repeat (8) begin
      reg_write("interrupt enable", REG_INTERRUPT_EN, {24'd0, 8'($urandom)});
      rd = 1'($urandom);
      run_transfer(rd, rd || 1'($urandom), 1'($urandom), 1'($urandom),
                   i2c_byte_t'($urandom));
      expect_read("interrupt pending", REG_INTERRUPT);
      d = {24'd0, 8'($urandom)};
      reg_write("interrupt clear", REG_INTERRUPT, d);
      expect_read("interrupt after clear", REG_INTERRUPT);
      check_irq_line("interrupt line after clear");
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  --top-module tb_axi_lite_i2c \
  -f axi_lite_i2c.f \
  -o sim_axi_lite_i2c
./obj_dir/sim_axi_lite_i2c

// ==== src/axi_lite_i2c.sv ====
/* AXI-Lite I2C master top: AXI slave port, register file, byte engine */
`default_nettype none

module axi_lite_i2c (
  input  wire                          clk,
  input  wire                          w_axi_rst,
  input  wire                          i_awvalid,
  input  wire i2c_ctrl_pkg::reg_addr_t i_awaddr,
  output logic                         o_awready,
  input  wire                          i_wvalid,
  input  wire i2c_ctrl_pkg::reg_data_t i_wdata,
  output logic                         o_wready,
  output logic                         o_bvalid,
  input  wire                          i_bready,
  output i2c_ctrl_pkg::axi_resp_t      o_bresp,
  input  wire                          i_arvalid,
  input  wire i2c_ctrl_pkg::reg_addr_t i_araddr,
  output logic                         o_arready,
  output logic                         o_rvalid,
  input  wire                          i_rready,
  output i2c_ctrl_pkg::axi_resp_t      o_rresp,
  output i2c_ctrl_pkg::reg_data_t      o_rdata,
  input  wire                          i_sda,
  output logic                         o_scl_oe,
  output logic                         o_sda_oe,
  output logic                         o_interrupt
);
  import i2c_ctrl_pkg::*;

  reg_wr_t     reg_wr;
  reg_idx_t    rd_idx;
  reg_data_t   rd_data;
  logic        rd_invalid;
  logic        wr_invalid;
  i2c_cmd_t    cmd;
  i2c_result_t result;

  axi_lite_slave axi0 (
    .clk(clk), .w_axi_rst(w_axi_rst),
    .i_awvalid(i_awvalid), .i_awaddr(i_awaddr), .o_awready(o_awready),
    .i_wvalid(i_wvalid), .i_wdata(i_wdata), .o_wready(o_wready),
    .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
    .i_arvalid(i_arvalid), .i_araddr(i_araddr), .o_arready(o_arready),
    .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rresp(o_rresp), .o_rdata(o_rdata),
    .o_reg_wr(reg_wr), .o_rd_idx(rd_idx), .i_rd_data(rd_data),
    .i_rd_invalid(rd_invalid), .i_wr_invalid(wr_invalid)
  );

  i2c_reg_file regs0 (
    .clk(clk), .w_axi_rst(w_axi_rst),
    .i_reg_wr(reg_wr), .i_rd_idx(rd_idx), .o_rd_data(rd_data),
    .o_rd_invalid(rd_invalid), .o_wr_invalid(wr_invalid),
    .o_cmd(cmd), .i_result(result), .o_interrupt(o_interrupt)
  );

  i2c_byte_engine eng0 (
    .clk(clk), .w_axi_rst(w_axi_rst),
    .i_cmd(cmd), .o_result(result),
    .i_sda(i_sda), .o_scl_oe(o_scl_oe), .o_sda_oe(o_sda_oe)
  );

endmodule

`default_nettype wire

// ==== src/axi_lite_slave.sv ====
/* AXI-Lite slave port: AW/W/B and AR/R handshakes,
   byte address to word index mapping, response codes */
`default_nettype none

module axi_lite_slave (
  input  wire                       clk,
  input  wire                       w_axi_rst,

  input  wire                       i_awvalid,
  input  wire i2c_ctrl_pkg::reg_addr_t i_awaddr,
  output logic                      o_awready,

  input  wire                       i_wvalid,
  input  wire i2c_ctrl_pkg::reg_data_t i_wdata,
  output logic                      o_wready,

  output logic                      o_bvalid,
  input  wire                       i_bready,
  output i2c_ctrl_pkg::axi_resp_t   o_bresp,

  input  wire                       i_arvalid,
  input  wire i2c_ctrl_pkg::reg_addr_t i_araddr,
  output logic                      o_arready,

  output logic                      o_rvalid,
  input  wire                       i_rready,
  output i2c_ctrl_pkg::axi_resp_t   o_rresp,
  output i2c_ctrl_pkg::reg_data_t   o_rdata,

  output i2c_ctrl_pkg::reg_wr_t     o_reg_wr,
  output i2c_ctrl_pkg::reg_idx_t    o_rd_idx,
  input  wire i2c_ctrl_pkg::reg_data_t i_rd_data,
  input  wire                       i_rd_invalid,
  input  wire                       i_wr_invalid
);
  import i2c_ctrl_pkg::*;

  logic aw_fire;
  logic ar_fire;

  // Address and data are taken together, only while B is free
  assign o_awready = !o_bvalid;
  assign o_wready  = !o_bvalid;
  assign aw_fire   = i_awvalid && i_wvalid && o_awready && o_wready;

  assign o_arready = !o_rvalid;
  assign ar_fire   = i_arvalid && o_arready;

  always_comb begin
    o_reg_wr.valid = aw_fire;
    o_reg_wr.idx   = i_awaddr[7:2];
    o_reg_wr.data  = i_wdata;
  end

  assign o_rd_idx = i_araddr[7:2];

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      o_bvalid <= 1'b0;
      o_rvalid <= 1'b0;
    end else begin
      if (aw_fire) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (ar_fire) begin
        o_rvalid <= 1'b1;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  // Response payload, captured at acceptance
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      o_bresp <= i_wr_invalid ? RESP_SLVERR : RESP_OKAY;
    end
    if (ar_fire) begin
      o_rdata <= i_rd_data;
      o_rresp <= i_rd_invalid ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

// ==== src/i2c_byte_engine.sv ====
/* I2C byte engine: start condition, eight data bits with acknowledge,
   stop condition, on open-drain SCL/SDA output enables */
`default_nettype none

module i2c_byte_engine (
  input  wire                        clk,
  input  wire                        w_axi_rst,
  input  wire i2c_ctrl_pkg::i2c_cmd_t i_cmd,
  output i2c_ctrl_pkg::i2c_result_t  o_result,
  input  wire                        i_sda,
  output logic                       o_scl_oe,
  output logic                       o_sda_oe
);
  import i2c_ctrl_pkg::*;

  engine_state_t state;
  logic [1:0]    phase;
  clk_div_t      cnt;
  clk_div_t      div_q;
  logic [2:0]    bit_cnt;
  i2c_byte_t     sh;
  logic          sample_q;
  logic          rx_ack_q;
  logic          read_q, nack_q, stop_q;
  logic          done_q;
  logic          tick, phase_end, sample_en;
  logic          scl_nx, sda_nx;

  assign tick      = (cnt == div_q);
  assign phase_end = tick && (phase == 2'd3);
  // Outputs lag one clock, so this is mid SCL-high on the pins
  assign sample_en = (phase == 2'd2) && (cnt == '0);

  // Output enables per phase, 1 pulls the line low
  always_comb begin
    scl_nx = o_scl_oe;
    sda_nx = o_sda_oe;
    case (state)
      START: begin
        case (phase)
          2'd0: sda_nx = 1'b0;
          2'd1: begin
            scl_nx = 1'b0;
            sda_nx = 1'b0;
          end
          2'd2: begin
            scl_nx = 1'b0;
            sda_nx = 1'b1;
          end
          default: begin
            scl_nx = 1'b1;
            sda_nx = 1'b1;
          end
        endcase
      end
      BIT: begin
        scl_nx = (phase == 2'd0) || (phase == 2'd3);
        sda_nx = !read_q && !sh[7];
      end
      ACK: begin
        scl_nx = (phase == 2'd0) || (phase == 2'd3);
        sda_nx = read_q && !nack_q;
      end
      STOP: begin
        scl_nx = (phase == 2'd0);
        sda_nx = (phase == 2'd0) || (phase == 2'd1);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      state    <= IDLE;
      phase    <= '0;
      cnt      <= '0;
      bit_cnt  <= '0;
      done_q   <= 1'b0;
      o_scl_oe <= 1'b0;
      o_sda_oe <= 1'b0;
    end else begin
      o_scl_oe <= scl_nx;
      o_sda_oe <= sda_nx;
      done_q   <= 1'b0;
      if (state == IDLE) begin
        if (i_cmd.go) begin
          state   <= i_cmd.start ? START : BIT;
          phase   <= '0;
          cnt     <= '0;
          bit_cnt <= 3'd7;
        end
      end else if (tick) begin
        cnt   <= '0;
        phase <= phase + 2'd1;
        if (phase == 2'd3) begin
          case (state)
            START: state <= BIT;
            BIT: begin
              if (bit_cnt == '0) begin
                state <= ACK;
              end
              bit_cnt <= bit_cnt - 3'd1;
            end
            ACK: begin
              state  <= stop_q ? STOP : IDLE;
              done_q <= !stop_q;
            end
            default: begin
              state  <= IDLE;
              done_q <= 1'b1;
            end
          endcase
        end
      end else begin
        cnt <= cnt + 16'd1;
      end
    end
  end

  // Command latch, shift register and line samples
  always_ff @(posedge clk) begin
    if (state == IDLE && i_cmd.go) begin
      sh     <= i_cmd.tx;
      div_q  <= i_cmd.div;
      read_q <= i_cmd.read;
      nack_q <= i_cmd.nack;
      stop_q <= i_cmd.stop;
    end
    if (sample_en) begin
      sample_q <= i_sda;
    end
    if (phase_end && state == BIT) begin
      sh <= {sh[6:0], sample_q};
    end
    if (phase_end && state == ACK) begin
      rx_ack_q <= sample_q;
    end
  end

  always_comb begin
    o_result.done   = done_q;
    o_result.rx_ack = rx_ack_q;
    o_result.rx     = sh;
  end

endmodule

`default_nettype wire

// ==== src/i2c_ctrl_pkg.sv ====
/* Shared widths, register map, bit positions, version word,
   register access and engine command/result structs, engine states */
`default_nettype none

package i2c_ctrl_pkg;

  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [5:0]  reg_idx_t;
  typedef logic [7:0]  i2c_byte_t;
  typedef logic [15:0] clk_div_t;
  typedef logic [1:0]  axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // Word indices of the register map
  localparam reg_idx_t REG_CONTROL       = 6'd0;
  localparam reg_idx_t REG_STATUS        = 6'd1;
  localparam reg_idx_t REG_INTERRUPT     = 6'd2;
  localparam reg_idx_t REG_INTERRUPT_EN  = 6'd3;
  localparam reg_idx_t REG_CLOCK_RATE    = 6'd4;
  localparam reg_idx_t REG_CLOCK_DIVIDER = 6'd5;
  localparam reg_idx_t REG_COMMAND       = 6'd6;
  localparam reg_idx_t REG_TRANSMIT      = 6'd7;
  localparam reg_idx_t REG_RECEIVE       = 6'd8;
  localparam reg_idx_t REG_VERSION       = 6'd9;

  localparam int CTRL_CORE_EN_BIT = 0;
  localparam int CTRL_IEN_BIT     = 1;
  localparam int CTRL_400KHZ_BIT  = 2;
  localparam int CTRL_100KHZ_BIT  = 3;

  localparam int CMD_START_BIT = 0;
  localparam int CMD_STOP_BIT  = 1;
  localparam int CMD_READ_BIT  = 2;
  localparam int CMD_WRITE_BIT = 3;
  localparam int CMD_NACK_BIT  = 4;

  localparam int STAT_TIP_BIT   = 1;
  localparam int STAT_RXACK_BIT = 7;

  localparam int INT_DONE_BIT  = 0;
  localparam int INT_RXACK_BIT = 2;

  localparam reg_data_t CLOCK_RATE = 32'd50_000_000;
  // Four phases per SCL period
  localparam clk_div_t DIV_100KHZ = clk_div_t'(CLOCK_RATE / (4 * 100_000) - 1);
  localparam clk_div_t DIV_400KHZ = clk_div_t'(CLOCK_RATE / (4 * 400_000) - 1);

  // Major 1, minor 0, revision 0
  localparam reg_data_t VERSION_WORD = {4'd1, 8'd0, 4'd0, 16'd0};

  typedef struct packed {
    logic      valid;
    reg_idx_t  idx;
    reg_data_t data;
  } reg_wr_t;

  // A go without read is a write
  typedef struct packed {
    logic      go;
    logic      start;
    logic      stop;
    logic      read;
    logic      nack;
    i2c_byte_t tx;
    clk_div_t  div;
  } i2c_cmd_t;

  typedef struct packed {
    logic      done;
    logic      rx_ack;
    i2c_byte_t rx;
  } i2c_result_t;

  typedef enum logic [2:0] {
    IDLE,
    START,
    BIT,
    ACK,
    STOP
  } engine_state_t;

endpackage

`default_nettype wire

// ==== src/i2c_reg_file.sv ====
/* Register file: control, divider, command and transmit storage,
   transfer status tracking, pending interrupts and the interrupt line */
`default_nettype none

module i2c_reg_file (
  input  wire                           clk,
  input  wire                           w_axi_rst,
  input  wire i2c_ctrl_pkg::reg_wr_t    i_reg_wr,
  input  wire i2c_ctrl_pkg::reg_idx_t   i_rd_idx,
  output i2c_ctrl_pkg::reg_data_t       o_rd_data,
  output logic                          o_rd_invalid,
  output logic                          o_wr_invalid,
  output i2c_ctrl_pkg::i2c_cmd_t        o_cmd,
  input  wire i2c_ctrl_pkg::i2c_result_t i_result,
  output logic                          o_interrupt
);
  import i2c_ctrl_pkg::*;

  logic      core_en;
  logic      ien;
  clk_div_t  clk_div;
  logic      start, stop, read, write, nack;
  logic      go;
  logic      tip;
  logic      rxack;
  i2c_byte_t transmit;
  i2c_byte_t receive;
  logic [7:0] int_en;
  logic [7:0] int_pend;
  logic [7:0] int_set;
  logic [7:0] int_clr;
  reg_data_t  wd;

  assign wd           = i_reg_wr.data;
  assign o_wr_invalid = i_reg_wr.idx > REG_VERSION;
  assign o_rd_invalid = i_rd_idx > REG_VERSION;

  always_comb begin
    int_set = '0;
    int_set[INT_DONE_BIT]  = ien && i_result.done;
    // Only a fresh nack raises the rxack interrupt
    int_set[INT_RXACK_BIT] = ien && i_result.done && i_result.rx_ack && !rxack;
    int_clr = '0;
    if (i_reg_wr.valid && i_reg_wr.idx == REG_INTERRUPT) begin
      int_clr = wd[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (w_axi_rst) begin
      core_en  <= 1'b1;
      ien      <= 1'b0;
      clk_div  <= DIV_100KHZ;
      start    <= 1'b0;
      stop     <= 1'b0;
      read     <= 1'b0;
      write    <= 1'b0;
      nack     <= 1'b0;
      go       <= 1'b0;
      tip      <= 1'b0;
      rxack    <= 1'b0;
      transmit <= '0;
      receive  <= '0;
      int_en   <= '0;
      int_pend <= '0;
    end else begin
      go <= 1'b0;
      if (i_reg_wr.valid) begin
        case (i_reg_wr.idx)
          REG_CONTROL: begin
            core_en <= wd[CTRL_CORE_EN_BIT];
            ien     <= wd[CTRL_IEN_BIT];
            // 400 kHz wins over 100 kHz
            if (wd[CTRL_400KHZ_BIT]) begin
              clk_div <= DIV_400KHZ;
            end else if (wd[CTRL_100KHZ_BIT]) begin
              clk_div <= DIV_100KHZ;
            end
          end
          REG_INTERRUPT_EN:  int_en   <= wd[7:0];
          REG_CLOCK_DIVIDER: clk_div  <= wd[15:0];
          REG_TRANSMIT:      transmit <= wd[7:0];
          REG_COMMAND: begin
            // Command bits are frozen while a transfer runs
            if (!tip && !go) begin
              start <= wd[CMD_START_BIT];
              stop  <= wd[CMD_STOP_BIT];
              read  <= wd[CMD_READ_BIT];
              write <= wd[CMD_WRITE_BIT];
              nack  <= wd[CMD_NACK_BIT];
              go    <= core_en && (wd[CMD_READ_BIT] || wd[CMD_WRITE_BIT]);
            end
          end
          default: begin
          end
        endcase
      end
      if (go) begin
        tip <= 1'b1;
      end
      if (i_result.done) begin
        tip     <= 1'b0;
        start   <= 1'b0;
        stop    <= 1'b0;
        read    <= 1'b0;
        write   <= 1'b0;
        nack    <= 1'b0;
        rxack   <= i_result.rx_ack;
        receive <= i_result.rx;
      end
      int_pend <= (int_pend & ~int_clr) | int_set;
    end
  end

  always_comb begin
    o_cmd.go    = go;
    o_cmd.start = start;
    o_cmd.stop  = stop;
    o_cmd.read  = read;
    o_cmd.nack  = nack;
    o_cmd.tx    = transmit;
    o_cmd.div   = clk_div;
  end

  assign o_interrupt = ien && |(int_pend & int_en);

  always_comb begin
    o_rd_data = '0;
    case (i_rd_idx)
      REG_CONTROL: begin
        o_rd_data[CTRL_CORE_EN_BIT] = core_en;
        o_rd_data[CTRL_IEN_BIT]     = ien;
      end
      REG_STATUS: begin
        o_rd_data[STAT_TIP_BIT]   = tip;
        o_rd_data[STAT_RXACK_BIT] = rxack;
      end
      REG_INTERRUPT:     o_rd_data[7:0]  = int_pend;
      REG_INTERRUPT_EN:  o_rd_data[7:0]  = int_en;
      REG_CLOCK_RATE:    o_rd_data       = CLOCK_RATE;
      REG_CLOCK_DIVIDER: o_rd_data[15:0] = clk_div;
      REG_COMMAND: begin
        o_rd_data[CMD_START_BIT] = start;
        o_rd_data[CMD_STOP_BIT]  = stop;
        o_rd_data[CMD_READ_BIT]  = read;
        o_rd_data[CMD_WRITE_BIT] = write;
        o_rd_data[CMD_NACK_BIT]  = nack;
      end
      REG_TRANSMIT:      o_rd_data[7:0]  = transmit;
      REG_RECEIVE:       o_rd_data[7:0]  = receive;
      REG_VERSION:       o_rd_data       = VERSION_WORD;
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire
